// File: filelist.f
+incdir+rtl
rtl/frontEndPkg.sv
rtl/branchUnit.sv
rtl/pcSelect.sv
rtl/nextPcGen.sv
rtl/preIfStage.sv
tb/tbClock.sv
tb/preIfStage_checker.sv
tb/preIfStage_tb.sv

// File: run.sh
#!/bin/sh
# builds the pre-fetch stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f filelist.f --top-module preIfStage_tb \
    --Mdir obj_dir -o simPreIf
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

# keep running past assertion errors so the testbench reports the result
output=$(./obj_dir/simPreIf +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi

// File: tb/preIfStage_tb.sv
// pre-fetch stage testbench, random stimulus checked against a next-pc model
`include "frontEnd_defines.svh"

module preIfStage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MaxCycles = 2000;   // tests take about 860 cycles

    logic                   clk;
    logic                   rstN;
    logic                   pcWr;
    logic                   idIsJump;
    logic [`ADDR_W-1:0]     idPc;
    logic [`ADDR_W-1:0]     idInstr;
    frontEndPkg::BranchType exeBranchType;
    logic [`ADDR_W-1:0]     exePc;
    logic [`ADDR_W-1:0]     exeImm32;
    logic [`ADDR_W-1:0]     exeBusA;
    logic [`ADDR_W-1:0]     exeBusB;
    frontEndPkg::ExcEntry   memEntry;
    logic [`ADDR_W-1:0]     memEpc;
    logic [`ADDR_W-1:0]     memPc;
    logic [`ADDR_W-1:0]     excVector;
    logic [`ADDR_W-1:0]     pc;
    logic [`ADDR_W-1:0]     fetchAddr;
    logic                   fetchReq;
    logic                   pcAdEL;

    logic [`ADDR_W-1:0] expPc;            // model pc
    int                 errorCount = 0;
    int                 testErrors = 0;   // errors in the running test
    int                 checkCount = 0;
    int                 testCount = 0;
    int                 cycleCount = 0;
    int unsigned        seedInit;

    tbClock clkGen0 (.clk(clk));

    preIfStage dut0 (
        .clk           (clk),
        .rstN          (rstN),
        .pcWr          (pcWr),
        .idIsJump      (idIsJump),
        .idPc          (idPc),
        .idInstr       (idInstr),
        .exeBranchType (exeBranchType),
        .exePc         (exePc),
        .exeImm32      (exeImm32),
        .exeBusA       (exeBusA),
        .exeBusB       (exeBusB),
        .memEntry      (memEntry),
        .memEpc        (memEpc),
        .memPc         (memPc),
        .excVector     (excVector),
        .pc            (pc),
        .fetchAddr     (fetchAddr),
        .fetchReq      (fetchReq),
        .pcAdEL        (pcAdEL)
    );

    bind preIfStage preIfStage_checker checker0 (
        .clk       (clk),
        .rstN      (rstN),
        .pcWr      (pcWr),
        .pc        (pc),
        .fetchAddr (fetchAddr),
        .fetchReq  (fetchReq),
        .pcAdEL    (pcAdEL)
    );

    task automatic compareValue(input string name, input logic [`ADDR_W-1:0] got,
                                input logic [`ADDR_W-1:0] exp);
        checkCount++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
            errorCount++;
            testErrors++;
        end
    endtask

    // branch condition, conditional types compare rs signed against zero
    function automatic logic branchTaken(input frontEndPkg::BranchType bt,
                                         input logic [`ADDR_W-1:0] a,
                                         input logic [`ADDR_W-1:0] b);
        logic signed [`ADDR_W-1:0] sa;
        logic                      taken;
        sa = a;
        case (bt)
            frontEndPkg::brBeq:  taken = (a == b);
            frontEndPkg::brBne:  taken = (a != b);
            frontEndPkg::brBgez: taken = (sa >= 0);
            frontEndPkg::brBgtz: taken = (sa > 0);
            frontEndPkg::brBlez: taken = (sa <= 0);
            frontEndPkg::brBltz: taken = (sa < 0);
            frontEndPkg::brJr:   taken = 1'b1;
            default:             taken = 1'b0;
        endcase
        return taken;
    endfunction

    function automatic logic [`ADDR_W-1:0] branchTarget(input frontEndPkg::BranchType bt,
                                                         input logic [`ADDR_W-1:0] pcVal,
                                                         input logic [`ADDR_W-1:0] imm,
                                                         input logic [`ADDR_W-1:0] a);
        logic [`ADDR_W-1:0] target;
        if (bt == frontEndPkg::brJr) begin
            target = a;    // register jump
        end else begin
            target = pcVal + `ADDR_W'(4) + (imm << 2);
        end
        return target;
    endfunction

    // region of the slot after the jump, word index, two zero bits
    function automatic logic [`ADDR_W-1:0] jumpTarget(input logic [`ADDR_W-1:0] pcVal,
                                                       input logic [`ADDR_W-1:0] instr);
        logic [`ADDR_W-1:0] regionMask;
        logic [`ADDR_W-1:0] wordAddr;
        regionMask = '1 << (`JIMM_W + 2);                 // top four bits only
        wordAddr   = `ADDR_W'(instr[`JIMM_W-1:0]) * 4;    // field as a byte address
        return ((pcVal + `ADDR_W'(4)) & regionMask) | wordAddr;
    endfunction

    // source priority on the inputs now driven
    function automatic logic [`ADDR_W-1:0] predictNext();
        logic [`ADDR_W-1:0] next;
        if (memEntry == frontEndPkg::excTrap) begin
            next = excVector;
        end else if (memEntry == frontEndPkg::excEret) begin
            next = memEpc;
        end else if (memEntry == frontEndPkg::excRefetch) begin
            next = memPc;
        end else if (branchTaken(exeBranchType, exeBusA, exeBusB)) begin
            next = branchTarget(exeBranchType, exePc, exeImm32, exeBusA);
        end else if (idIsJump) begin
            next = jumpTarget(idPc, idInstr);
        end else begin
            next = expPc + `ADDR_W'(4);
        end
        return next;
    endfunction

    function automatic logic [`ADDR_W-1:0] randAligned();
        logic [`ADDR_W-1:0] r;
        r = $urandom();
        return {r[`ADDR_W-1:2], 2'b00};
    endfunction

    task automatic quietInputs();
        idIsJump      = 1'b0;
        exeBranchType = frontEndPkg::brNone;
        memEntry      = frontEndPkg::excNone;
    endtask

    // random branch, rs biased toward zero and rt
    task automatic randomBranch();
        logic [2:0]  randType;
        logic [15:0] imm16;
        int          pick;
        randType      = 3'($urandom_range(0, 7));
        exeBranchType = frontEndPkg::BranchType'(randType);
        exePc         = randAligned();
        imm16         = 16'($urandom());
        exeImm32      = {{16{imm16[15]}}, imm16};   // sign extended offset
        exeBusB       = $urandom();
        pick          = $urandom_range(0, 3);
        case (pick)
            0:       exeBusA = '0;
            1:       exeBusA = exeBusB;
            2:       exeBusA = randAligned() | 32'h8000_0000;   // negative
            default: exeBusA = $urandom();
        endcase
    endtask

    // one clock, model update then compare at the falling edge
    task automatic runCycle();
        if (pcWr) begin
            expPc = predictNext();
        end
        @(negedge clk);
        compareValue("pc", pc, expPc);
        compareValue("fetchAddr", fetchAddr, expPc);
        compareValue("pcAdEL", `ADDR_W'(pcAdEL), `ADDR_W'(|expPc[1:0]));
        compareValue("fetchReq", `ADDR_W'(fetchReq), `ADDR_W'(1));
    endtask

    task automatic finishTest(input string name, input int cycles);
        testCount++;
        $display("test %0d %s done, %0d cycles, %0d errors", testCount, name, cycles,
                 testErrors);
        testErrors = 0;
    endtask

    // hang guard
    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("timeout, run still going after %0d cycles", MaxCycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        seedInit  = $urandom(32'h26b5);   // seeds the generator once
        rstN      = 1'b0;
        pcWr      = 1'b1;
        idPc      = '0;
        idInstr   = '0;
        exePc     = '0;
        exeImm32  = '0;
        exeBusA   = '0;
        exeBusB   = '0;
        memEpc    = '0;
        memPc     = '0;
        excVector = '0;
        quietInputs();
        expPc = `PC_RESET;

        repeat (5) begin
            @(negedge clk);
            compareValue("pc", pc, `PC_RESET);
            compareValue("fetchReq", `ADDR_W'(fetchReq), '0);
        end
        rstN = 1'b1;
        runCycle();    // request rises, pc steps off the vector
        finishTest("reset", 6);

        for (int i = 0; i < 100; i++) begin
            pcWr = 1'($urandom_range(0, 1));
            runCycle();
        end
        finishTest("sequential and stall", 100);

        pcWr     = 1'b1;
        idIsJump = 1'b1;
        for (int i = 0; i < 100; i++) begin
            idPc    = randAligned();
            idInstr = $urandom();
            runCycle();
        end
        quietInputs();
        finishTest("immediate jump", 100);

        for (int i = 0; i < 300; i++) begin
            randomBranch();
            runCycle();
        end
        quietInputs();
        finishTest("branch resolution", 300);

        for (int i = 0; i < 300; i++) begin
            randomBranch();
            idIsJump  = 1'($urandom_range(0, 1));
            idPc      = randAligned();
            idInstr   = $urandom();
            memEntry  = frontEndPkg::ExcEntry'(2'($urandom_range(0, 3)));
            memEpc    = randAligned();
            memPc     = randAligned();
            excVector = randAligned();
            pcWr      = ($urandom_range(0, 3) != 0);   // mostly writing
            runCycle();
        end
        quietInputs();
        finishTest("priority", 300);

        pcWr          = 1'b1;
        exeBranchType = frontEndPkg::brJr;
        for (int i = 0; i < 25; i++) begin
            exeBusA = randAligned() | `ADDR_W'($urandom_range(1, 3));   // misaligned
            runCycle();
            exeBusA = randAligned();   // flag clears again
            runCycle();
        end
        quietInputs();
        finishTest("alignment", 50);

        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: tb/preIfStage_checker.sv
// pre-fetch stage assertion checker, pc hold, fetch address, alignment flag and reset request
`include "frontEnd_defines.svh"

module preIfStage_checker (
    input logic               clk,
    input logic               rstN,
    input logic               pcWr,
    input logic [`ADDR_W-1:0] pc,
    input logic [`ADDR_W-1:0] fetchAddr,
    input logic               fetchReq,
    input logic               pcAdEL
);
    timeunit 1ns;
    timeprecision 1ps;

    // stall keeps the pc
    pcHold: assert property (@(posedge clk) disable iff (!rstN) !pcWr |=> $stable(pc))
        else $error("pc changed while pcWr was low");

    // no tlb, fetch address is the pc
    addrMatch: assert property (@(posedge clk) disable iff (!rstN) fetchAddr == pc)
        else $error("fetchAddr differs from pc");

    // address error on either low bit
    adelFlag: assert property (@(posedge clk) disable iff (!rstN) pcAdEL == (|pc[1:0]))
        else $error("pcAdEL does not follow the low pc bits");

    // request stays down through reset
    reqInReset: assert property (@(posedge clk) !rstN |=> !fetchReq)
        else $error("fetchReq high during reset");

endmodule

// File: tb/tbClock.sv
// testbench clock source, free running 20 ns period
module tbClock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;    // first rising edge at 10 ns
    end

    always #10 clk = ~clk;    // half period

endmodule

// File: rtl/preIfStage.sv
// pre-fetch stage top, wires branch resolution, source select and pc generation
`include "frontEnd_defines.svh"

module preIfStage (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   pcWr,           // stall when low

    // id stage, immediate jump
    input  logic                   idIsJump,
    input  logic [`ADDR_W-1:0]     idPc,
    input  logic [`ADDR_W-1:0]     idInstr,

    // exe stage, branch / jr
    input  frontEndPkg::BranchType exeBranchType,
    input  logic [`ADDR_W-1:0]     exePc,
    input  logic [`ADDR_W-1:0]     exeImm32,
    input  logic [`ADDR_W-1:0]     exeBusA,
    input  logic [`ADDR_W-1:0]     exeBusB,

    // mem stage, exception entry and return
    input  frontEndPkg::ExcEntry   memEntry,
    input  logic [`ADDR_W-1:0]     memEpc,         // cp0 epc
    input  logic [`ADDR_W-1:0]     memPc,          // refetch address
    input  logic [`ADDR_W-1:0]     excVector,

    output logic [`ADDR_W-1:0]     pc,             // to if stage
    output logic [`ADDR_W-1:0]     fetchAddr,      // to icache, virt == phys
    output logic                   fetchReq,
    output logic                   pcAdEL
);

    logic               exeRedirect;   // taken in exe
    logic [`ADDR_W-1:0] exeTarget;
    frontEndPkg::PcSel  pcSel;

    // condition and target from exe operands
    branchUnit branch0 (
        .exeBranchType (exeBranchType),
        .exePc         (exePc),
        .exeImm32      (exeImm32),
        .exeBusA       (exeBusA),
        .exeBusB       (exeBusB),
        .exeRedirect   (exeRedirect),
        .exeTarget     (exeTarget)
    );

    // fixed priority, mem > exe > id > seq
    pcSelect select0 (
        .memEntry    (memEntry),
        .exeRedirect (exeRedirect),
        .idIsJump    (idIsJump),
        .pcSel       (pcSel)
    );

    // pc register and outputs
    nextPcGen pcGen0 (
        .clk       (clk),
        .rstN      (rstN),
        .pcWr      (pcWr),
        .pcSel     (pcSel),
        .idPc      (idPc),
        .idInstr   (idInstr),
        .exeTarget (exeTarget),
        .memEpc    (memEpc),
        .memPc     (memPc),
        .excVector (excVector),
        .pc        (pc),
        .fetchReq  (fetchReq),
        .pcAdEL    (pcAdEL)
    );

    // no tlb, fetch goes out on the pc itself
    assign fetchAddr = pc;

endmodule

// File: rtl/nextPcGen.sv
// next-pc generation, target adders, source mux, pc register and fetch request
`include "frontEnd_defines.svh"

module nextPcGen (
    input  logic               clk,
    input  logic               rstN,
    input  logic               pcWr,       // low stalls the pc
    input  frontEndPkg::PcSel  pcSel,
    input  logic [`ADDR_W-1:0] idPc,
    input  logic [`ADDR_W-1:0] idInstr,
    input  logic [`ADDR_W-1:0] exeTarget,  // from branchUnit
    input  logic [`ADDR_W-1:0] memEpc,
    input  logic [`ADDR_W-1:0] memPc,
    input  logic [`ADDR_W-1:0] excVector,
    output logic [`ADDR_W-1:0] pc,
    output logic               fetchReq,
    output logic               pcAdEL      // instruction address error
);

    logic [`ADDR_W-1:0] seqPc;      // pc + 4
    logic [`ADDR_W-1:0] idPcAdd4;   // region source for j
    logic [`ADDR_W-1:0] jumpTarget;
    logic [`ADDR_W-1:0] nextPc;

    assign seqPc    = pc + `ADDR_W'(4);
    assign idPcAdd4 = idPc + `ADDR_W'(4);

    // 256MB region of the slot after the jump, then the word index
    assign jumpTarget = {idPcAdd4[`ADDR_W-1:`JIMM_W+2],
                         idInstr[`JIMM_W-1:0],
                         2'b00};

    // six way source mux
    always_comb begin
        unique case (pcSel)
            frontEndPkg::selSeq:     nextPc = seqPc;
            frontEndPkg::selJump:    nextPc = jumpTarget;
            frontEndPkg::selEpc:     nextPc = memEpc;      // eret
            frontEndPkg::selVector:  nextPc = excVector;   // exception entry
            frontEndPkg::selExe:     nextPc = exeTarget;
            frontEndPkg::selRefetch: nextPc = memPc;       // replay
            default:                 nextPc = seqPc;       // unused codes
        endcase
    end

    // pc register
    // write enable is the only back-pressure, a stall repeats the address
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= `PC_RESET;
        end else if (pcWr) begin
            pc <= nextPc;
        end
    end

    // fetch request
    // low in reset, up on the first edge after release and stays there
    always_ff @(posedge clk) begin
        if (!rstN) begin
            fetchReq <= 1'b0;
        end else begin
            fetchReq <= 1'b1;
        end
    end

    // adel on any misaligned pc, jr is the usual source
    assign pcAdEL = |pc[1:0];

endmodule

// File: rtl/pcSelect.sv
// next-pc source priority, mem entry over exe redirect over id jump over pc+4
module pcSelect (
    input  frontEndPkg::ExcEntry memEntry,     // oldest redirect
    input  logic                 exeRedirect,  // taken branch or jr
    input  logic                 idIsJump,     // immediate jump in id
    output frontEndPkg::PcSel    pcSel
);

    // older stage always wins
    // a younger redirect is on the wrong path once an older one fires
    always_comb begin
        pcSel = frontEndPkg::selSeq;   // nothing redirects
        if (memEntry != frontEndPkg::excNone) begin
            // mem entry picks its own source
            unique case (memEntry)
                frontEndPkg::excTrap:    pcSel = frontEndPkg::selVector;
                frontEndPkg::excEret:    pcSel = frontEndPkg::selEpc;
                frontEndPkg::excRefetch: pcSel = frontEndPkg::selRefetch;
                default:                 pcSel = frontEndPkg::selSeq;
            endcase
        end else if (exeRedirect) begin
            pcSel = frontEndPkg::selExe;     // resolved branch / jr
        end else if (idIsJump) begin
            pcSel = frontEndPkg::selJump;    // j / jal
        end
    end

endmodule

// File: rtl/branchUnit.sv
// exe branch resolution, evaluates the condition and forms the redirect target
`include "frontEnd_defines.svh"

module branchUnit (
    input  frontEndPkg::BranchType exeBranchType,
    input  logic [`ADDR_W-1:0]     exePc,
    input  logic [`ADDR_W-1:0]     exeImm32,    // sign extended offset, words
    input  logic [`ADDR_W-1:0]     exeBusA,     // rs after forwarding
    input  logic [`ADDR_W-1:0]     exeBusB,     // rt after forwarding
    output logic                   exeRedirect,
    output logic [`ADDR_W-1:0]     exeTarget
);

    logic              busEq;       // rs == rt
    logic              busANeg;     // sign bit of rs
    logic              busAZero;    // rs == 0
    logic              condTrue;
    logic [`ADDR_W-1:0] offsetSh;   // offset << 2
    logic [`ADDR_W-1:0] relTarget;  // pc relative target

    assign busEq    = (exeBusA == exeBusB);
    assign busANeg  = $signed(exeBusA) < 0;   // signed compare against zero
    assign busAZero = (exeBusA == '0);

    // byte offset, top two bits of imm drop out
    assign offsetSh  = {exeImm32[`ADDR_W-3:0], 2'b00};
    // target relative to the slot after the branch
    assign relTarget = exePc + `ADDR_W'(4) + offsetSh;

    // condition per opcode
    always_comb begin
        unique case (exeBranchType)
            frontEndPkg::brBeq:  condTrue = busEq;
            frontEndPkg::brBne:  condTrue = !busEq;
            frontEndPkg::brBgez: condTrue = !busANeg;
            frontEndPkg::brBgtz: condTrue = !busANeg && !busAZero;  // strictly positive
            frontEndPkg::brBlez: condTrue = busANeg || busAZero;
            frontEndPkg::brBltz: condTrue = busANeg;
            frontEndPkg::brJr:   condTrue = 1'b1;    // always taken
            default:             condTrue = 1'b0;    // brNone
        endcase
    end

    assign exeRedirect = condTrue;

    // jr takes the register, every other type the relative target
    // target is don't-care when not redirecting, so no gating here
    assign exeTarget = (exeBranchType == frontEndPkg::brJr) ? exeBusA : relTarget;

endmodule

// File: rtl/frontEndPkg.sv
// front end package with control-transfer, exception-entry and next-pc select types
package frontEndPkg;

    // control transfer resolved in exe
    // conditional types read busA (and busB for beq/bne)
    typedef enum logic [2:0] {
        brNone = 3'd0,  // plain instruction, no redirect
        brBeq  = 3'd1,  // busA == busB
        brBne  = 3'd2,  // busA != busB
        brBgez = 3'd3,  // busA >= 0, signed
        brBgtz = 3'd4,  // busA > 0
        brBlez = 3'd5,  // busA <= 0
        brBltz = 3'd6,  // busA < 0
        brJr   = 3'd7   // register jump, target is busA
    } BranchType;

    // entry request from mem stage
    // oldest stage, so it beats every other redirect
    typedef enum logic [1:0] {
        excNone    = 2'd0,  // nothing pending
        excTrap    = 2'd1,  // go to exception vector
        excEret    = 2'd2,  // return to epc
        excRefetch = 2'd3   // replay from mem pc
    } ExcEntry;

    // next-pc mux select
    // encoding follows the mux input order in nextPcGen
    typedef enum logic [2:0] {
        selSeq     = 3'd0,  // pc + 4
        selJump    = 3'd1,  // id immediate jump
        selEpc     = 3'd2,  // eret
        selVector  = 3'd3,  // exception entry
        selExe     = 3'd4,  // branch or jr from exe
        selRefetch = 3'd5   // mem pc again
    } PcSel;

    // values 6 and 7 of PcSel are never produced
    // the mux falls back to pc + 4 for them

endpackage

// File: rtl/frontEnd_defines.svh
// front end defines, address width, reset vector and jump field size
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// datapath and address width
// pc, operands and targets all share it
`define ADDR_W 32

// boot vector in kseg1, uncached rom
`define PC_RESET 32'hBFC0_0000

// j / jal immediate field, instr[25:0]
// shifted left by two to form the word address
`define JIMM_W 26

// jump target layout
//   [31:28] from pc+4 of the jump
//   [27:2]  immediate field
//   [1:0]   always zero

`endif
